// ==== rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data path and pc width.
`define CPU_WIDTH 64

// register index width, 32 integer registers.
`define REG_ADDRW 5

// initial credits, one per free consumer slot.
`define CORE_CREDITS 4

`endif

// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

  // major opcodes, inst[6:0].
  typedef enum logic [6:0] {
    TYPE_R       = 7'b0110011,
    TYPE_R_W     = 7'b0111011,
    TYPE_I       = 7'b0010011,
    TYPE_I_W     = 7'b0011011,
    TYPE_I_LOAD  = 7'b0000011,
    TYPE_I_JALR  = 7'b1100111,
    TYPE_I_EBRK  = 7'b1110011,   // whole system group.
    TYPE_S       = 7'b0100011,
    TYPE_B       = 7'b1100011,
    TYPE_U_LUI   = 7'b0110111,
    TYPE_U_AUIPC = 7'b0010111,
    TYPE_J       = 7'b1101111
  } opcode_e;

  typedef enum logic [4:0] {
    EXU_ADD,
    EXU_SUB,
    EXU_SLL,
    EXU_SLT,
    EXU_SLTU,
    EXU_XOR,
    EXU_SRL,
    EXU_SRA,
    EXU_OR,
    EXU_AND,
    EXU_ADDW,
    EXU_SUBW,
    EXU_SLLW,
    EXU_SRLW,
    EXU_SRAW,
    EXU_BEQ,
    EXU_BNE,
    EXU_BLT,
    EXU_BGE,
    EXU_BLTU,
    EXU_BGEU,
    EXU_ILL                      // not supported here.
  } exu_op_e;

  typedef enum logic [1:0] {
    SEL_REG,                     // alu on rs1, rs2.
    SEL_IMM,                     // alu on rs1, imm.
    SEL_PC4,                     // result is pc + 4.
    SEL_PCI                      // result is pc + imm.
  } src_sel_e;

endpackage

// ==== rv_pipe_pkg.sv ====
`include "rv_defs.svh"

package rv_pipe_pkg;

  typedef struct packed {
    logic [`REG_ADDRW-1:0] rs1;
    logic [`REG_ADDRW-1:0] rs2;
    logic [`REG_ADDRW-1:0] rd;
    logic                  rdwen;
    logic [`CPU_WIDTH-1:0] imm;
    rv_isa_pkg::exu_op_e   op;
    rv_isa_pkg::src_sel_e  src_sel;
    logic                  brch;
    logic                  jal;
    logic                  jalr;
    logic                  ill;
  } dec_t;

  typedef struct packed {
    logic [`CPU_WIDTH-1:0] pc;
    logic [31:0]           ins;
  } ins_t;

  typedef struct packed {
    logic [`CPU_WIDTH-1:0] pc;
    logic [`REG_ADDRW-1:0] rd;
    logic                  wen;
    logic [`CPU_WIDTH-1:0] result;
    logic                  taken;
    logic [`CPU_WIDTH-1:0] target;   // branch or jump destination.
    logic                  ill;
  } wb_t;

endpackage

// ==== idu.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module idu (
  input  logic [31:0]       i_ins,
  output rv_pipe_pkg::dec_t o_dec
);

  logic [`REG_ADDRW-1:0] rs1id;
  logic [`REG_ADDRW-1:0] rs2id;
  logic [`REG_ADDRW-1:0] rdid;
  logic [2:0]            func3;
  rv_isa_pkg::opcode_e   opcode;

  logic [`REG_ADDRW-1:0] rs1_sel;
  logic [`REG_ADDRW-1:0] rs2_sel;
  logic [`REG_ADDRW-1:0] rd_sel;
  logic                  rd_en;
  logic [`CPU_WIDTH-1:0] imm;
  rv_isa_pkg::exu_op_e   op;
  rv_isa_pkg::src_sel_e  src_sel;
  logic                  ill;

  assign rs2id  = i_ins[24:20];
  assign rs1id  = i_ins[19:15];
  assign func3  = i_ins[14:12];
  assign rdid   = i_ins[11:7];
  assign opcode = rv_isa_pkg::opcode_e'(i_ins[6:0]);

  // register indices and sign-extended immediate.
  always_comb begin
    rs1_sel = '0;
    rs2_sel = '0;
    rd_sel  = '0;
    rd_en   = 1'b0;
    imm     = '0;
    case (opcode)
      rv_isa_pkg::TYPE_R, rv_isa_pkg::TYPE_R_W: begin
        rs1_sel = rs1id;
        rs2_sel = rs2id;
        rd_sel  = rdid;
        rd_en   = 1'b1;
      end
      rv_isa_pkg::TYPE_I, rv_isa_pkg::TYPE_I_W, rv_isa_pkg::TYPE_I_JALR: begin
        rs1_sel = rs1id;
        rd_sel  = rdid;
        rd_en   = 1'b1;
        imm     = {{(`CPU_WIDTH-12){i_ins[31]}}, i_ins[31:20]};
      end
      rv_isa_pkg::TYPE_B: begin
        rs1_sel = rs1id;
        rs2_sel = rs2id;
        imm     = {{(`CPU_WIDTH-13){i_ins[31]}}, i_ins[31], i_ins[7],
                   i_ins[30:25], i_ins[11:8], 1'b0};
      end
      rv_isa_pkg::TYPE_U_LUI, rv_isa_pkg::TYPE_U_AUIPC: begin
        rd_sel  = rdid;                              // lui adds to x0.
        rd_en   = 1'b1;
        imm     = {{(`CPU_WIDTH-32){i_ins[31]}}, i_ins[31:12], 12'b0};
      end
      rv_isa_pkg::TYPE_J: begin
        rd_sel  = rdid;
        rd_en   = 1'b1;
        imm     = {{(`CPU_WIDTH-21){i_ins[31]}}, i_ins[31], i_ins[19:12],
                   i_ins[20], i_ins[30:21], 1'b0};
      end
      default: ;                                     // loads, stores, system.
    endcase
  end

  // execute operation and operand source.
  always_comb begin
    op      = rv_isa_pkg::EXU_ILL;
    src_sel = rv_isa_pkg::SEL_IMM;
    case (opcode)
      rv_isa_pkg::TYPE_R: begin
        src_sel = rv_isa_pkg::SEL_REG;
        if (!i_ins[25]) begin                        // bit 25 is the m extension.
          case (func3)
            3'b000:  op = i_ins[30] ? rv_isa_pkg::EXU_SUB : rv_isa_pkg::EXU_ADD;
            3'b001:  op = rv_isa_pkg::EXU_SLL;
            3'b010:  op = rv_isa_pkg::EXU_SLT;
            3'b011:  op = rv_isa_pkg::EXU_SLTU;
            3'b100:  op = rv_isa_pkg::EXU_XOR;
            3'b101:  op = i_ins[30] ? rv_isa_pkg::EXU_SRA : rv_isa_pkg::EXU_SRL;
            3'b110:  op = rv_isa_pkg::EXU_OR;
            default: op = rv_isa_pkg::EXU_AND;
          endcase
        end
      end
      rv_isa_pkg::TYPE_R_W: begin
        src_sel = rv_isa_pkg::SEL_REG;
        if (!i_ins[25]) begin
          case (func3)
            3'b000:  op = i_ins[30] ? rv_isa_pkg::EXU_SUBW : rv_isa_pkg::EXU_ADDW;
            3'b001:  op = rv_isa_pkg::EXU_SLLW;
            3'b101:  op = i_ins[30] ? rv_isa_pkg::EXU_SRAW : rv_isa_pkg::EXU_SRLW;
            default: ;
          endcase
        end
      end
      rv_isa_pkg::TYPE_I: begin
        case (func3)
          3'b000:  op = rv_isa_pkg::EXU_ADD;
          3'b001:  op = rv_isa_pkg::EXU_SLL;
          3'b010:  op = rv_isa_pkg::EXU_SLT;
          3'b011:  op = rv_isa_pkg::EXU_SLTU;
          3'b100:  op = rv_isa_pkg::EXU_XOR;
          3'b101:  op = i_ins[30] ? rv_isa_pkg::EXU_SRA : rv_isa_pkg::EXU_SRL;
          3'b110:  op = rv_isa_pkg::EXU_OR;
          default: op = rv_isa_pkg::EXU_AND;
        endcase
      end
      rv_isa_pkg::TYPE_I_W: begin
        case (func3)
          3'b000:  op = rv_isa_pkg::EXU_ADDW;
          3'b001:  op = rv_isa_pkg::EXU_SLLW;
          3'b101:  op = i_ins[30] ? rv_isa_pkg::EXU_SRAW : rv_isa_pkg::EXU_SRLW;
          default: ;
        endcase
      end
      rv_isa_pkg::TYPE_B: begin
        src_sel = rv_isa_pkg::SEL_REG;
        case (func3)
          3'b000:  op = rv_isa_pkg::EXU_BEQ;
          3'b001:  op = rv_isa_pkg::EXU_BNE;
          3'b100:  op = rv_isa_pkg::EXU_BLT;
          3'b101:  op = rv_isa_pkg::EXU_BGE;
          3'b110:  op = rv_isa_pkg::EXU_BLTU;
          3'b111:  op = rv_isa_pkg::EXU_BGEU;
          default: ;
        endcase
      end
      rv_isa_pkg::TYPE_I_JALR, rv_isa_pkg::TYPE_J: begin
        op      = rv_isa_pkg::EXU_ADD;
        src_sel = rv_isa_pkg::SEL_PC4;               // rd = pc + 4.
      end
      rv_isa_pkg::TYPE_U_LUI:   op = rv_isa_pkg::EXU_ADD;
      rv_isa_pkg::TYPE_U_AUIPC: begin
        op      = rv_isa_pkg::EXU_ADD;
        src_sel = rv_isa_pkg::SEL_PCI;
      end
      default: ;
    endcase
  end

  assign ill = (op == rv_isa_pkg::EXU_ILL);

  always_comb begin
    o_dec.rs1     = rs1_sel;
    o_dec.rs2     = rs2_sel;
    o_dec.rd      = rd_sel;
    o_dec.rdwen   = rd_en & ~ill;
    o_dec.imm     = imm;
    o_dec.op      = op;
    o_dec.src_sel = src_sel;
    o_dec.brch    = (opcode == rv_isa_pkg::TYPE_B) & ~ill;
    o_dec.jal     = (opcode == rv_isa_pkg::TYPE_J);
    o_dec.jalr    = (opcode == rv_isa_pkg::TYPE_I_JALR);
    o_dec.ill     = ill;
  end

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module regfile (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_we,
  input  logic [`REG_ADDRW-1:0] i_waddr,
  input  logic [`CPU_WIDTH-1:0] i_wdata,
  input  logic [`REG_ADDRW-1:0] i_raddr1,
  input  logic [`REG_ADDRW-1:0] i_raddr2,
  output logic [`CPU_WIDTH-1:0] o_rdata1,
  output logic [`CPU_WIDTH-1:0] o_rdata2
);

  localparam int NREGS = 1 << `REG_ADDRW;

  logic [`CPU_WIDTH-1:0] regs [0:NREGS-1];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_waddr != '0)) begin   // x0 stays zero.
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// ==== exu.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module exu (
  input  rv_pipe_pkg::dec_t     i_dec,
  input  logic [`CPU_WIDTH-1:0] i_pc,
  input  logic [`CPU_WIDTH-1:0] i_rs1,
  input  logic [`CPU_WIDTH-1:0] i_rs2,
  output rv_pipe_pkg::wb_t      o_wb
);

  logic [`CPU_WIDTH-1:0] opb;
  logic [`CPU_WIDTH-1:0] alu_res;
  logic [`CPU_WIDTH-1:0] res_sel;
  logic [`CPU_WIDTH-1:0] pc4;
  logic [`CPU_WIDTH-1:0] pci;
  logic [`CPU_WIDTH-1:0] jalr_sum;
  logic [31:0]           w_res;
  logic [5:0]            shamt;
  logic [4:0]            shamt_w;
  logic                  cmp_taken;

  assign opb      = (i_dec.src_sel == rv_isa_pkg::SEL_REG) ? i_rs2 : i_dec.imm;
  assign shamt    = opb[5:0];
  assign shamt_w  = opb[4:0];
  assign pc4      = i_pc + `CPU_WIDTH'd4;
  assign pci      = i_pc + i_dec.imm;
  assign jalr_sum = i_rs1 + i_dec.imm;

  // 32-bit forms on the low word.
  always_comb begin
    case (i_dec.op)
      rv_isa_pkg::EXU_ADDW: w_res = i_rs1[31:0] + opb[31:0];
      rv_isa_pkg::EXU_SUBW: w_res = i_rs1[31:0] - opb[31:0];
      rv_isa_pkg::EXU_SLLW: w_res = i_rs1[31:0] << shamt_w;
      rv_isa_pkg::EXU_SRLW: w_res = i_rs1[31:0] >> shamt_w;
      rv_isa_pkg::EXU_SRAW: w_res = 32'($signed(i_rs1[31:0]) >>> shamt_w);
      default:              w_res = '0;
    endcase
  end

  always_comb begin
    case (i_dec.op)
      rv_isa_pkg::EXU_ADD:  alu_res = i_rs1 + opb;
      rv_isa_pkg::EXU_SUB:  alu_res = i_rs1 - opb;
      rv_isa_pkg::EXU_SLL:  alu_res = i_rs1 << shamt;
      rv_isa_pkg::EXU_SLT:  alu_res = `CPU_WIDTH'($signed(i_rs1) < $signed(opb));
      rv_isa_pkg::EXU_SLTU: alu_res = `CPU_WIDTH'(i_rs1 < opb);
      rv_isa_pkg::EXU_XOR:  alu_res = i_rs1 ^ opb;
      rv_isa_pkg::EXU_SRL:  alu_res = i_rs1 >> shamt;
      rv_isa_pkg::EXU_SRA:  alu_res = `CPU_WIDTH'($signed(i_rs1) >>> shamt);
      rv_isa_pkg::EXU_OR:   alu_res = i_rs1 | opb;
      rv_isa_pkg::EXU_AND:  alu_res = i_rs1 & opb;
      rv_isa_pkg::EXU_ADDW, rv_isa_pkg::EXU_SUBW, rv_isa_pkg::EXU_SLLW,
      rv_isa_pkg::EXU_SRLW, rv_isa_pkg::EXU_SRAW:
        alu_res = {{(`CPU_WIDTH-32){w_res[31]}}, w_res};  // sign-extend low word.
      default:              alu_res = '0;
    endcase
  end

  always_comb begin
    case (i_dec.op)
      rv_isa_pkg::EXU_BEQ:  cmp_taken = (i_rs1 == i_rs2);
      rv_isa_pkg::EXU_BNE:  cmp_taken = (i_rs1 != i_rs2);
      rv_isa_pkg::EXU_BLT:  cmp_taken = ($signed(i_rs1) < $signed(i_rs2));
      rv_isa_pkg::EXU_BGE:  cmp_taken = ($signed(i_rs1) >= $signed(i_rs2));
      rv_isa_pkg::EXU_BLTU: cmp_taken = (i_rs1 < i_rs2);
      rv_isa_pkg::EXU_BGEU: cmp_taken = (i_rs1 >= i_rs2);
      default:              cmp_taken = 1'b0;
    endcase
  end

  always_comb begin
    case (i_dec.src_sel)
      rv_isa_pkg::SEL_PC4: res_sel = pc4;
      rv_isa_pkg::SEL_PCI: res_sel = pci;
      default:             res_sel = alu_res;
    endcase
  end

  always_comb begin
    o_wb.pc     = i_pc;
    o_wb.rd     = i_dec.rd;
    o_wb.wen    = i_dec.rdwen;
    o_wb.result = i_dec.rdwen ? res_sel : '0;           // zero when nothing is written.
    o_wb.taken  = i_dec.brch ? cmp_taken : (i_dec.jal | i_dec.jalr);
    if (i_dec.jalr) begin
      o_wb.target = {jalr_sum[`CPU_WIDTH-1:1], 1'b0};   // lsb cleared.
    end else if (i_dec.brch || i_dec.jal) begin
      o_wb.target = pci;
    end else begin
      o_wb.target = '0;
    end
    o_wb.ill    = i_dec.ill;
  end

endmodule

// ==== core_top.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module core_top (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_ins_valid,
  input  rv_pipe_pkg::ins_t i_ins,
  output logic              o_ins_ready,
  output logic              o_wb_valid,
  output rv_pipe_pkg::wb_t  o_wb,
  input  logic              i_credit
);

  localparam int CRW = $clog2(`CORE_CREDITS + 1);

  logic [CRW-1:0]        credit_cnt;
  logic                  ins_fire;
  rv_pipe_pkg::dec_t     dec_d;
  logic                  s1_valid;
  logic [`CPU_WIDTH-1:0] s1_pc;
  rv_pipe_pkg::dec_t     s1_dec;
  logic [`CPU_WIDTH-1:0] rf_rdata1;
  logic [`CPU_WIDTH-1:0] rf_rdata2;
  logic                  fwd1;
  logic                  fwd2;
  logic [`CPU_WIDTH-1:0] rs1_val;
  logic [`CPU_WIDTH-1:0] rs2_val;
  rv_pipe_pkg::wb_t      wb_d;

  assign o_ins_ready = (credit_cnt != '0);     // no buffering inside the core.
  assign ins_fire    = i_ins_valid & o_ins_ready;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      credit_cnt <= CRW'(`CORE_CREDITS);
    end else begin
      credit_cnt <= credit_cnt + CRW'(i_credit) - CRW'(ins_fire);
    end
  end

  idu u_idu (.i_ins(i_ins.ins), .o_dec(dec_d));

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_valid   <= 1'b0;
      o_wb_valid <= 1'b0;
    end else begin
      s1_valid   <= ins_fire;
      o_wb_valid <= s1_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (ins_fire) begin
      s1_pc  <= i_ins.pc;
      s1_dec <= dec_d;
    end
    if (s1_valid) begin
      o_wb <= wb_d;
    end
  end

  // stage 2 reaches the register file one edge later, so bypass it.
  assign fwd1    = o_wb_valid && o_wb.wen && (s1_dec.rs1 != '0) && (o_wb.rd == s1_dec.rs1);
  assign fwd2    = o_wb_valid && o_wb.wen && (s1_dec.rs2 != '0) && (o_wb.rd == s1_dec.rs2);
  assign rs1_val = fwd1 ? o_wb.result : rf_rdata1;
  assign rs2_val = fwd2 ? o_wb.result : rf_rdata2;

  regfile u_regfile (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_we     (o_wb_valid & o_wb.wen),
    .i_waddr  (o_wb.rd),
    .i_wdata  (o_wb.result),
    .i_raddr1 (s1_dec.rs1),
    .i_raddr2 (s1_dec.rs2),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2)
  );

  exu u_exu (
    .i_dec (s1_dec),
    .i_pc  (s1_pc),
    .i_rs1 (rs1_val),
    .i_rs2 (rs2_val),
    .o_wb  (wb_d)
  );

endmodule

// ==== core_sva.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module core_sva (
  input logic                                 i_clk,
  input logic                                 i_rst,
  input logic                                 i_ins_valid,
  input logic                                 i_ins_ready,
  input logic                                 i_wb_valid,
  input logic [$clog2(`CORE_CREDITS + 1)-1:0] i_credit_cnt
);

  int fail_count = 0;

  a_no_accept_without_credit: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_credit_cnt == '0) |-> !(i_ins_valid && i_ins_ready))
    else begin
      fail_count++;
      $error("beat accepted while no credit was held");
    end

  a_credit_max: assert property (@(posedge i_clk) disable iff (i_rst)
    i_credit_cnt <= `CORE_CREDITS)
    else begin
      fail_count++;
      $error("credit count above its initial value");
    end

  a_wb_low_after_reset: assert property (@(posedge i_clk) i_rst |=> !i_wb_valid)
    else begin
      fail_count++;
      $error("record valid in the cycle after reset");
    end

  // fixed two-stage latency.
  a_wb_latency: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_ins_valid && i_ins_ready) |-> ##2 i_wb_valid)
    else begin
      fail_count++;
      $error("accepted beat gave no record two cycles later");
    end

endmodule

bind core_top core_sva u_sva (
  .i_clk        (i_clk),
  .i_rst        (i_rst),
  .i_ins_valid  (i_ins_valid),
  .i_ins_ready  (o_ins_ready),
  .i_wb_valid   (o_wb_valid),
  .i_credit_cnt (credit_cnt)
);

// ==== tb_core.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module tb_core;

  localparam int NUM_RECORDS = 2000;
  localparam int LATENCY     = 2;        // sampled edges from accept to record.
  localparam int WAIT_LIMIT  = 200;

  typedef struct packed {
    rv_pipe_pkg::wb_t rec;
    logic [31:0]      acc_cyc;
    logic             chk_target;
  } exp_t;

  logic                  clk;
  logic                  rst;
  logic                  ins_valid;
  rv_pipe_pkg::ins_t     ins;
  logic                  ins_ready;
  logic                  wb_valid;
  rv_pipe_pkg::wb_t      wb;
  logic                  credit;

  logic [`CPU_WIDTH-1:0] model_regs [0:31];
  exp_t                  exp_q [$];
  int                    credit_due_q [$];
  int                    cyc = 0;
  int                    n_acc = 0;
  int                    n_ret = 0;
  int                    n_checked = 0;
  int                    last_due = -1;

  core_top DUT (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_ins_valid (ins_valid),
    .i_ins       (ins),
    .o_ins_ready (ins_ready),
    .o_wb_valid  (wb_valid),
    .o_wb        (wb),
    .i_credit    (credit)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string field, input logic [63:0] got,
                                 input logic [63:0] want);
    stop_on_error($sformatf("CHECK FAILED at %0t ns: %s got %h expected %h",
                            $time, field, got, want));
  endtask

  function automatic logic [`CPU_WIDTH-1:0] alu_64(input logic [2:0] f3, input logic alt,
                                                   input logic [`CPU_WIDTH-1:0] a,
                                                   input logic [`CPU_WIDTH-1:0] b);
    logic [`CPU_WIDTH-1:0] r;
    case (f3)
      3'd0:    r = alt ? a - b : a + b;
      3'd1:    r = a << b[5:0];
      3'd2:    r = `CPU_WIDTH'($signed(a) < $signed(b));
      3'd3:    r = `CPU_WIDTH'(a < b);
      3'd4:    r = a ^ b;
      3'd5: begin
        if (alt) r = $signed(a) >>> b[5:0];
        else     r = a >> b[5:0];
      end
      3'd6:    r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // low word only, result sign-extended.
  function automatic logic [`CPU_WIDTH-1:0] alu_32(input logic [2:0] f3, input logic alt,
                                                   input logic [`CPU_WIDTH-1:0] a,
                                                   input logic [`CPU_WIDTH-1:0] b);
    logic [31:0] t;
    case (f3)
      3'd0:    t = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
      3'd1:    t = a[31:0] << b[4:0];
      default: begin
        if (alt) t = $signed(a[31:0]) >>> b[4:0];
        else     t = a[31:0] >> b[4:0];
      end
    endcase
    return {{(`CPU_WIDTH-32){t[31]}}, t};
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [`CPU_WIDTH-1:0] a,
                                        input logic [`CPU_WIDTH-1:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  // reference model, runs at acceptance in program order.
  task automatic predict(input rv_pipe_pkg::ins_t beat, output exp_t e);
    logic [31:0]           w;
    logic [2:0]            f3;
    logic [`CPU_WIDTH-1:0] a;
    logic [`CPU_WIDTH-1:0] b;
    logic [`CPU_WIDTH-1:0] imm_i;
    logic [`CPU_WIDTH-1:0] imm_b;
    logic [`CPU_WIDTH-1:0] imm_u;
    logic [`CPU_WIDTH-1:0] imm_j;
    w     = beat.ins;
    f3    = w[14:12];
    a     = model_regs[w[19:15]];
    b     = model_regs[w[24:20]];
    imm_i = {{(`CPU_WIDTH-12){w[31]}}, w[31:20]};
    imm_b = {{(`CPU_WIDTH-13){w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {{(`CPU_WIDTH-32){w[31]}}, w[31:12], 12'b0};
    imm_j = {{(`CPU_WIDTH-21){w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    e        = '0;
    e.rec.pc = beat.pc;
    e.rec.rd = w[11:7];
    case (w[6:0])
      rv_isa_pkg::TYPE_R: begin
        e.rec.ill    = w[25];                         // m extension.
        e.rec.wen    = !w[25];
        e.rec.result = alu_64(f3, w[30], a, b);
      end
      rv_isa_pkg::TYPE_I: begin
        e.rec.wen    = 1'b1;
        e.rec.result = alu_64(f3, (f3 == 3'd5) && w[30], a, imm_i);
      end
      rv_isa_pkg::TYPE_R_W: begin
        e.rec.ill    = w[25] || !(f3 inside {3'd0, 3'd1, 3'd5});
        e.rec.wen    = !e.rec.ill;
        e.rec.result = alu_32(f3, w[30], a, b);
      end
      rv_isa_pkg::TYPE_I_W: begin
        e.rec.ill    = !(f3 inside {3'd0, 3'd1, 3'd5});
        e.rec.wen    = !e.rec.ill;
        e.rec.result = alu_32(f3, (f3 == 3'd5) && w[30], a, imm_i);
      end
      rv_isa_pkg::TYPE_U_LUI: begin
        e.rec.wen    = 1'b1;
        e.rec.result = imm_u;
      end
      rv_isa_pkg::TYPE_U_AUIPC: begin
        e.rec.wen    = 1'b1;
        e.rec.result = beat.pc + imm_u;
      end
      rv_isa_pkg::TYPE_J, rv_isa_pkg::TYPE_I_JALR: begin
        e.rec.wen    = 1'b1;
        e.rec.result = beat.pc + 4;
        e.rec.taken  = 1'b1;
        e.chk_target = 1'b1;
        if (w[6:0] == rv_isa_pkg::TYPE_J) e.rec.target = beat.pc + imm_j;
        else e.rec.target = (a + imm_i) & ~`CPU_WIDTH'(1);
      end
      rv_isa_pkg::TYPE_B: begin
        e.rec.ill    = (f3 == 3'd2) || (f3 == 3'd3);
        e.rec.taken  = !e.rec.ill && branch_taken(f3, a, b);
        e.rec.target = beat.pc + imm_b;
        e.chk_target = !e.rec.ill;
      end
      default: e.rec.ill = 1'b1;                      // loads, stores, system, unknown.
    endcase
    if (!e.rec.wen) e.rec.result = '0;
    if (e.rec.wen && e.rec.rd != '0) model_regs[e.rec.rd] = e.rec.result;
  endtask

  // random instruction word over x0..x7.
  function automatic logic [31:0] gen_word();
    logic [31:0] w;
    logic [2:0]  f3;
    int          kind;
    int          idx;
    w        = $urandom();
    kind     = $urandom_range(0, 99);
    idx      = $urandom_range(0, 2);
    w[11:7]  = 5'($urandom_range(0, 7));
    w[19:15] = 5'($urandom_range(0, 7));
    w[24:20] = 5'($urandom_range(0, 7));
    f3       = w[14:12];
    if (kind < 20) begin
      w[6:0]   = rv_isa_pkg::TYPE_R;
      w[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && w[31]) ? 7'h20 : 7'h00;
    end else if (kind < 30 || (kind >= 50 && kind < 58)) begin
      f3       = (idx == 0) ? 3'd0 : (idx == 1) ? 3'd1 : 3'd5;
      w[14:12] = f3;
      w[6:0]   = (kind < 30) ? rv_isa_pkg::TYPE_R_W : rv_isa_pkg::TYPE_I_W;
      if (kind < 30 || f3 != 3'd0) w[31:25] = (f3 != 3'd1 && w[31]) ? 7'h20 : 7'h00;
    end else if (kind < 50) begin
      w[6:0] = rv_isa_pkg::TYPE_I;
      if (f3 == 3'd1 || (f3 == 3'd5 && !w[31])) w[31:26] = 6'b000000;
      else if (f3 == 3'd5) w[31:26] = 6'b010000;
    end else if (kind < 63) begin
      w[6:0] = rv_isa_pkg::TYPE_U_LUI;
    end else if (kind < 68) begin
      w[6:0] = rv_isa_pkg::TYPE_U_AUIPC;
    end else if (kind < 73) begin
      w[6:0] = rv_isa_pkg::TYPE_J;
    end else if (kind < 78) begin
      w[6:0]   = rv_isa_pkg::TYPE_I_JALR;
      w[14:12] = 3'd0;
    end else if (kind < 90) begin
      f3       = 3'($urandom_range(0, 5));
      w[14:12] = (f3 >= 3'd2) ? f3 + 3'd2 : f3;      // skip the two unused codes.
      w[6:0]   = rv_isa_pkg::TYPE_B;
    end else begin
      case ($urandom_range(0, 4))
        0:       w[6:0] = rv_isa_pkg::TYPE_I_LOAD;
        1:       w[6:0] = rv_isa_pkg::TYPE_S;
        2:       w = 32'h0010_0073;                   // ebreak.
        3: begin
          w[6:0]   = rv_isa_pkg::TYPE_R;
          w[31:25] = 7'h01;
        end
        default: w[6:0] = w[1] ? 7'b0001011 : 7'b0101011;
      endcase
    end
    return w;
  endfunction

  // returns credits one per cycle, 0 to 6 cycles after each record.
  initial begin
    credit = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      if (credit_due_q.size() > 0 && credit_due_q[0] <= cyc) begin
        void'(credit_due_q.pop_front());
        credit = 1'b1;
      end else begin
        credit = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    exp_t expc;
    int   due;
    if (!rst) begin
      assert (DUT.u_sva.fail_count == 0) else
        stop_on_error("a bound protocol assertion on the core failed");
      if (ins_valid && ins_ready) begin
        predict(ins, expc);
        expc.acc_cyc = cyc;
        exp_q.push_back(expc);
        n_acc++;
      end
      if (credit) n_ret++;
      assert (n_acc - n_ret <= `CORE_CREDITS) else
        stop_on_error($sformatf("CHECK FAILED at %0t ns: %0d records outstanding",
                                $time, n_acc - n_ret));
      if (wb_valid) begin
        assert (exp_q.size() > 0) else
          stop_on_error("core produced a record with no instruction in flight");
        expc = exp_q.pop_front();
        assert (cyc - int'(expc.acc_cyc) == LATENCY) else
          report_mismatch("latency", cyc - int'(expc.acc_cyc), LATENCY);
        compare_record(wb, expc);
        n_checked++;
        due = cyc + 1 + $urandom_range(0, 6);
        if (due <= last_due) due = last_due + 1;
        last_due = due;
        credit_due_q.push_back(due);
      end
    end
    cyc++;
  end

  task automatic compare_record(input rv_pipe_pkg::wb_t got, input exp_t want);
    assert (got.pc == want.rec.pc) else report_mismatch("pc", got.pc, want.rec.pc);
    assert (got.ill == want.rec.ill) else report_mismatch("ill", got.ill, want.rec.ill);
    assert (got.wen == want.rec.wen) else report_mismatch("wen", got.wen, want.rec.wen);
    assert (got.taken == want.rec.taken) else
      report_mismatch("taken", got.taken, want.rec.taken);
    if (want.rec.wen) begin
      assert (got.rd == want.rec.rd) else report_mismatch("rd", got.rd, want.rec.rd);
      assert (got.result == want.rec.result) else
        report_mismatch("result", got.result, want.rec.result);
    end
    if (want.chk_target) begin
      assert (got.target == want.rec.target) else
        report_mismatch("target", got.target, want.rec.target);
    end
  endtask

  initial begin
    rv_pipe_pkg::ins_t beat;
    int                gap;
    int                waited;
    logic              accepted;
    void'($urandom(42));
    rst       = 1'b1;
    ins_valid = 1'b0;
    ins       = '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int n = 0; n < NUM_RECORDS; n++) begin
      gap = $urandom_range(0, 3);
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      beat.pc   = {$urandom(), $urandom()} & ~`CPU_WIDTH'(3);
      beat.ins  = gen_word();
      ins       = beat;
      ins_valid = 1'b1;
      accepted  = 1'b0;
      waited    = 0;
      while (!accepted) begin
        @(posedge clk);
        accepted = ins_ready;
        waited++;
        #1;
        if (!accepted && waited >= WAIT_LIMIT) begin
          stop_on_error("timeout: core did not accept an instruction for 200 cycles");
        end
      end
      ins_valid = 1'b0;
    end
    waited = 0;
    while (n_checked < NUM_RECORDS && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    #1;
    if (n_checked == NUM_RECORDS && exp_q.size() == 0 && DUT.u_sva.fail_count == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      stop_on_error($sformatf("run ended with %0d of %0d records and %0d assertion errors",
                              n_checked, NUM_RECORDS, DUT.u_sva.fail_count));
    end
  end

endmodule

// ==== compile.f ====
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
idu.sv
regfile.sv
exu.sv
core_top.sv
core_sva.sv
tb_core.sv
